//--- cpu_testdata.hex
// first the program length, then the program words loaded from the reset pc on.
// then the trace length and one line per traced write: pc, wnum, wdata.
0000001f
02bff404 02801405 00101486 00111487
00121488 00129489 0014148a 0014948b
0015148c 0015948d 1500002e 00408dcf
004491d0 004891d1 2984000e 28840012
580008ca 02800413 5c0008ca 02804413
5c000885 02800414 58000885 02815400
00101414 54000800 02800415 4c000c36
02800417 0281dc17 50000000
00000015
1c000000 00000004 fffffffd
1c000004 00000005 00000005
1c000008 00000006 00000002
1c00000c 00000007 fffffff8
1c000010 00000008 00000001
1c000014 00000009 00000000
1c000018 0000000a 00000002
1c00001c 0000000b 00000005
1c000020 0000000c fffffffd
1c000024 0000000d fffffff8
1c000028 0000000e 80001000
1c00002c 0000000f 00008000
1c000030 00000010 08000100
1c000034 00000011 f8000100
1c00003c 00000012 80001000
1c00004c 00000013 00000011
1c00005c 00000000 00000055
1c000060 00000014 00000005
1c000064 00000001 1c000068
1c00006c 00000016 1c000070
1c000074 00000017 00000077

//--- sources.f
+incdir+.
cpu_pkg.sv
rf_if.sv
cpu_decoder.sv
cpu_alu.sv
cpu_regfile.sv
mycpu_top.sv
tb_clock_gen.sv
tb_top.sv

//--- Makefile
TOP = tb_top
RTL = cpu_pkg.sv rf_if.sv cpu_decoder.sv cpu_alu.sv cpu_regfile.sv mycpu_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall +incdir+. $(RTL) --top-module mycpu_top

sim:
	verilator --binary --timing -j 0 -f sources.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- tb_top.sv
`include "cpu_macros.svh"

module tb_top
    import cpu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD_NS = 4;
    localparam int TDATA_WORDS   = 256;

    logic             clk;
    logic             reset;
    logic             inst_sram_we;
    logic [`XLEN-1:0] inst_sram_addr;
    logic [`XLEN-1:0] inst_sram_wdata;
    logic [`XLEN-1:0] inst_sram_rdata = '0;
    logic             data_sram_we;
    logic [`XLEN-1:0] data_sram_addr;
    logic [`XLEN-1:0] data_sram_wdata;
    logic [`XLEN-1:0] data_sram_rdata = '0;
    logic [`XLEN-1:0] debug_wb_pc;
    logic [3:0]       debug_wb_rf_we;
    logic [4:0]       debug_wb_rf_wnum;
    logic [`XLEN-1:0] debug_wb_rf_wdata;

    logic [`XLEN-1:0] testdata [0:TDATA_WORDS-1];
    logic [`XLEN-1:0] imem [0:255];
    logic [`XLEN-1:0] dmem [0:255];
    logic [`XLEN-1:0] inst_word_q;
    logic [`XLEN-1:0] data_word_q;
    int               word_count  = 0;
    int               trace_count = 0;
    int               trace_idx   = 0;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    mycpu_top uut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic pc_check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("error %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic wnum_check(input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            abort_run($sformatf("error debug_wb_rf_wnum expected %h actual %h", exp, act));
        end
    endtask

    task automatic wdata_check(input logic [`XLEN-1:0] exp, input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("error debug_wb_rf_wdata expected %h actual %h", exp, act));
        end
    endtask

    function automatic logic [7:0] imem_index(input logic [`XLEN-1:0] addr);
        logic [`XLEN-1:0] offs;
        offs = addr - `RESET_PC;
        return offs[9:2];
    endfunction

    // trace entries follow the program and the trace count.
    function automatic logic [`XLEN-1:0] trace_word(input int entry, input int field);
        logic [7:0] idx;
        idx = 8'(word_count + 2 + 3 * entry + field);
        return testdata[idx];
    endfunction

    initial begin : load_program
        $readmemh("cpu_testdata.hex", testdata);
        word_count = int'(testdata[0]);
        if (word_count < 1 || word_count > 120) begin
            abort_run("the test data file holds no usable program");
        end
        trace_count = int'(testdata[8'(word_count + 1)]);
        if (trace_count < 1 || word_count + 2 + 3 * trace_count > TDATA_WORDS) begin
            abort_run("the test data file holds no usable trace");
        end
        for (int i = 0; i < word_count; i++) begin
            imem[8'(i)] = testdata[8'(i + 1)];
        end
    end

    // both srams register the read at the rising edge, outputs move on the falling edge.
    always @(posedge clk) begin
        inst_word_q <= imem[imem_index(inst_sram_addr)];
        data_word_q <= dmem[data_sram_addr[9:2]];
        if (data_sram_we) begin
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        end
    end

    always @(negedge clk) begin
        inst_sram_rdata <= inst_word_q;
        data_sram_rdata <= data_word_q;
    end

    initial begin : reset_state_check
        @(negedge reset);
        pc_check("inst_sram_addr", `RESET_PC, inst_sram_addr);
        if (data_sram_we !== 1'b0 || debug_wb_rf_we !== 4'h0) begin
            abort_run("a store or a register write is active right after reset");
        end
    end

    // the instruction sram is read only.
    always @(posedge clk) begin
        if (!reset) begin
            pc_check("inst_sram_we", 32'h0, {31'b0, inst_sram_we});
            pc_check("inst_sram_wdata", 32'h0, inst_sram_wdata);
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            if (debug_wb_rf_we === 4'hf) begin
                abort_run("a register write was traced while reset was high");
            end
        end else if (debug_wb_rf_we != 4'h0) begin
            if (debug_wb_rf_we != 4'hf) begin
                abort_run("debug_wb_rf_we has only some of its bits set");
            end
            if (trace_idx >= trace_count) begin
                abort_run("a register write was traced after the last expected entry");
            end
            pc_check("debug_wb_pc", trace_word(trace_idx, 0), debug_wb_pc);
            wnum_check(reg_addr_t'(trace_word(trace_idx, 1)), debug_wb_rf_wnum);
            wdata_check(trace_word(trace_idx, 2), debug_wb_rf_wdata);
            trace_idx = trace_idx + 1;
        end
    end

    initial begin : finish_on_trace
        wait (trace_count > 0 && trace_idx == trace_count);
        @(negedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

    // no instruction takes more than five cycles.
    initial begin : watchdog
        wait (trace_count > 0);
        #((trace_count + word_count) * 5 * CLK_PERIOD_NS + 200);
        abort_run($sformatf("the trace did not complete, %0d of %0d writes seen",
                            trace_idx, trace_count));
    end

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release on a falling edge so the core sees a clean first cycle.
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- mycpu_top.sv
`include "cpu_macros.svh"

module mycpu_top
    import cpu_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    output logic             inst_sram_we,
    output logic [`XLEN-1:0] inst_sram_addr,
    output logic [`XLEN-1:0] inst_sram_wdata,
    input  logic [`XLEN-1:0] inst_sram_rdata,
    output logic             data_sram_we,
    output logic [`XLEN-1:0] data_sram_addr,
    output logic [`XLEN-1:0] data_sram_wdata,
    input  logic [`XLEN-1:0] data_sram_rdata,
    output logic [`XLEN-1:0] debug_wb_pc,
    output logic [3:0]       debug_wb_rf_we,
    output logic [4:0]       debug_wb_rf_wnum,
    output logic [`XLEN-1:0] debug_wb_rf_wdata
);
    cpu_state_t       state;
    cpu_state_t       next_state;
    inst_word_t       inst_q;
    inst_word_t       dec_inst;
    ctrl_t            ctrl;
    ctrl_t            ctrl_q;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] npc_q;
    logic [`XLEN-1:0] next_pc;
    logic [`XLEN-1:0] br_target;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] br_offs;
    logic [`XLEN-1:0] src1_q;
    logic [`XLEN-1:0] src2_q;
    logic [`XLEN-1:0] rkd_q;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] alu_res_q;
    logic             br_taken;
    logic             branch_only;

    rf_if rf ();

    // the fetched word is only valid on the SRAM port during ID.
    assign dec_inst = (state == st_id) ? inst_sram_rdata : inst_q;

    cpu_decoder u_decoder (
        .inst    (dec_inst),
        .ctrl    (ctrl),
        .imm     (imm),
        .br_offs (br_offs),
        .rf      (rf.rd_addr)
    );

    cpu_regfile u_regfile (
        .clk (clk),
        .rf  (rf.regs)
    );

    cpu_alu u_alu (
        .op     (ctrl_q.alu_op),
        .src1   (src1_q),
        .src2   (src2_q),
        .result (alu_result)
    );

    always_comb begin
        case (ctrl.br_kind)
            br_always: br_taken = 1'b1;
            br_jirl:   br_taken = 1'b1;
            br_eq:     br_taken = (rf.rdata1 == rf.rdata2);
            br_ne:     br_taken = (rf.rdata1 != rf.rdata2);
            default:   br_taken = 1'b0;
        endcase
    end

    assign br_target   = (ctrl.br_kind == br_jirl) ? rf.rdata1 + br_offs : pc + br_offs;
    assign next_pc     = br_taken ? br_target : pc + 32'd4;
    // b, beq and bne finish in ID.
    assign branch_only = (ctrl.br_kind != br_none) && !ctrl.gr_we;

    always_comb begin
        case (state)
            st_if:   next_state = st_id;
            st_id:   next_state = branch_only ? st_if : st_exe;
            st_exe:  next_state = (ctrl_q.is_load || ctrl_q.is_store) ? st_mem : st_wb;
            st_mem:  next_state = ctrl_q.is_load ? st_wb : st_if;
            default: next_state = st_if;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_if;
            pc           <= `RESET_PC;
            ctrl_q       <= '0;
            data_sram_we <= 1'b0;
        end else begin
            state <= next_state;
            // pc moves on the last edge of every instruction.
            if (next_state == st_if) begin
                pc <= (state == st_id) ? next_pc : npc_q;
            end
            if (state == st_id) begin
                ctrl_q <= ctrl;
            end
            data_sram_we <= (next_state == st_mem) && ctrl_q.mem_we;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_id) begin
            inst_q <= inst_sram_rdata;
            npc_q  <= next_pc;
            src1_q <= ctrl.src1_is_pc ? pc : rf.rdata1;
            src2_q <= ctrl.src2_is_imm ? imm : rf.rdata2;
            rkd_q  <= rf.rdata2;
        end
        if (state == st_exe) begin
            alu_res_q <= alu_result;
            if (next_state == st_mem) begin
                data_sram_addr  <= alu_result;
                data_sram_wdata <= rkd_q;
            end
        end
    end

    // load data arrives one cycle after MEM presented the address.
    assign rf.we    = (state == st_wb) && ctrl_q.gr_we;
    assign rf.waddr = ctrl_q.dest;
    assign rf.wdata = ctrl_q.res_from_mem ? data_sram_rdata : alu_res_q;

    assign inst_sram_we    = 1'b0;
    assign inst_sram_addr  = pc;
    assign inst_sram_wdata = '0;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf.we}};
    assign debug_wb_rf_wnum  = rf.waddr;
    assign debug_wb_rf_wdata = rf.wdata;

    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

    store_in_mem: assert property (
        @(posedge clk) disable iff (reset) data_sram_we |-> state == st_mem
    );

endmodule

//--- cpu_regfile.sv
`include "cpu_macros.svh"

module cpu_regfile (
    input logic clk,
    rf_if.regs  rf
);
    // r0 has no storage.
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (rf.we && rf.waddr != '0) begin
            regs[rf.waddr] <= rf.wdata;
        end
    end

    assign rf.rdata1 = (rf.raddr1 == '0) ? '0 : regs[rf.raddr1];
    assign rf.rdata2 = (rf.raddr2 == '0) ? '0 : regs[rf.raddr2];

endmodule

//--- cpu_alu.sv
`include "cpu_macros.svh"

module cpu_alu
    import cpu_pkg::*;
(
    input  alu_op_t          op,
    input  logic [`XLEN-1:0] src1,
    input  logic [`XLEN-1:0] src2,
    output logic [`XLEN-1:0] result
);
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = src2[4:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            alu_add:  result = src1 + src2;
            alu_sub:  result = src1 - src2;
            alu_slt:  result = {{(`XLEN-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            alu_and:  result = src1 & src2;
            alu_nor:  result = ~(src1 | src2);
            alu_or:   result = src1 | src2;
            alu_xor:  result = src1 ^ src2;
            alu_sll:  result = src1 << shamt;
            alu_srl:  result = src1 >> shamt;
            alu_sra:  result = $signed(src1) >>> shamt;
            // lu12i.w arrives with the immediate already shifted.
            alu_lui:  result = src2;
            default:  result = '0;
        endcase
    end

endmodule

//--- cpu_decoder.sv
`include "cpu_macros.svh"

module cpu_decoder
    import cpu_pkg::*;
(
    input  inst_word_t       inst,
    output ctrl_t            ctrl,
    output logic [`XLEN-1:0] imm,
    output logic [`XLEN-1:0] br_offs,
    rf_if.rd_addr            rf
);
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    logic        r3_hit;
    logic        need_ui5;
    logic        need_si12;
    logic        need_si20;
    logic        need_si26;
    logic        src2_is_4;
    logic        src_reg_is_rd;

    // wider offsets borrow the low opcode bits of the 2RI12 view.
    assign i12 = inst.imm.i12;
    assign i16 = {inst.imm.opcode[3:0], inst.imm.i12};
    assign i20 = {inst.imm.opcode[2:0], inst.imm.i12, inst.imm.rj};
    assign i26 = {inst.imm.rj, inst.imm.rd, i16};

    always_comb begin
        ctrl          = '0;
        ctrl.dest     = inst.reg3.rd;
        r3_hit        = 1'b1;
        need_si12     = 1'b0;
        need_si20     = 1'b0;
        need_si26     = 1'b0;
        src2_is_4     = 1'b0;
        src_reg_is_rd = 1'b0;
        case (inst.reg3.opcode)
            17'h00020: ctrl.alu_op = alu_add;
            17'h00022: ctrl.alu_op = alu_sub;
            17'h00024: ctrl.alu_op = alu_slt;
            17'h00025: ctrl.alu_op = alu_sltu;
            17'h00028: ctrl.alu_op = alu_nor;
            17'h00029: ctrl.alu_op = alu_and;
            17'h0002a: ctrl.alu_op = alu_or;
            17'h0002b: ctrl.alu_op = alu_xor;
            17'h00081: ctrl.alu_op = alu_sll;
            17'h00089: ctrl.alu_op = alu_srl;
            17'h00091: ctrl.alu_op = alu_sra;
            default:   r3_hit = 1'b0;
        endcase
        // the shift-by-immediate group is the only 3R match with bit 7 set.
        need_ui5   = r3_hit & inst.reg3.opcode[7];
        ctrl.gr_we = r3_hit;
        casez (inst.imm.opcode)
            10'h00a: begin
                need_si12  = 1'b1;
                ctrl.gr_we = 1'b1;
            end
            10'h0a2: begin
                need_si12         = 1'b1;
                ctrl.is_load      = 1'b1;
                ctrl.res_from_mem = 1'b1;
                ctrl.gr_we        = 1'b1;
            end
            10'h0a6: begin
                need_si12     = 1'b1;
                ctrl.is_store = 1'b1;
                ctrl.mem_we   = 1'b1;
                src_reg_is_rd = 1'b1;
            end
            10'b0100_11??_??: begin
                ctrl.br_kind = br_jirl;
                src2_is_4    = 1'b1;
                ctrl.gr_we   = 1'b1;
            end
            10'b0101_00??_??: begin
                ctrl.br_kind = br_always;
                need_si26    = 1'b1;
            end
            10'b0101_01??_??: begin
                ctrl.br_kind = br_always;
                need_si26    = 1'b1;
                src2_is_4    = 1'b1;
                ctrl.gr_we   = 1'b1;
                ctrl.dest    = 5'd1;
            end
            10'b0101_10??_??: begin
                ctrl.br_kind  = br_eq;
                src_reg_is_rd = 1'b1;
            end
            10'b0101_11??_??: begin
                ctrl.br_kind  = br_ne;
                src_reg_is_rd = 1'b1;
            end
            10'b0001_010?_??: begin
                ctrl.alu_op = alu_lui;
                need_si20   = 1'b1;
                ctrl.gr_we  = 1'b1;
            end
            default: ;
        endcase
        // link value is pc + 4.
        ctrl.src1_is_pc  = src2_is_4;
        ctrl.src2_is_imm = need_ui5 | need_si12 | need_si20 | src2_is_4;
    end

    assign imm = src2_is_4 ? 32'd4 :
                 need_si20 ? {i20, 12'b0} :
                 need_ui5  ? {27'b0, inst.reg3.rk} :
                             {{20{i12[11]}}, i12};

    assign br_offs = need_si26 ? {{4{i26[25]}}, i26, 2'b00} : {{14{i16[15]}}, i16, 2'b00};

    assign rf.raddr1 = inst.reg3.rj;
    assign rf.raddr2 = src_reg_is_rd ? inst.reg3.rd : inst.reg3.rk;

    // the state machine relies on these classes being exclusive.
    always_comb begin
        if (!$isunknown(inst)) begin
            assert #0 ($onehot0({ctrl.is_load, ctrl.is_store, ctrl.br_kind != br_none}));
        end
    end

endmodule

//--- rf_if.sv
`include "cpu_macros.svh"

interface rf_if
    import cpu_pkg::*;
();
    reg_addr_t        raddr1;
    reg_addr_t        raddr2;
    reg_addr_t        waddr;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic [`XLEN-1:0] wdata;
    logic             we;

    modport rd_addr (output raddr1, output raddr2);
    modport wr (output we, output waddr, output wdata);
    modport regs (
        input  raddr1, input raddr2, input we, input waddr, input wdata,
        output rdata1, output rdata2
    );
endinterface

//--- cpu_pkg.sv
package cpu_pkg;

    typedef logic [4:0] reg_addr_t;

    // one instruction word, read in the 3R layout or the 2RI12 layout.
    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            reg_addr_t   rk;
            reg_addr_t   rj;
            reg_addr_t   rd;
        } reg3;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] i12;
            reg_addr_t   rj;
            reg_addr_t   rd;
        } imm;
    } inst_word_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_nor, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_t;

    typedef enum logic [2:0] {st_if, st_id, st_exe, st_mem, st_wb} cpu_state_t;

    typedef enum logic [2:0] {br_none, br_always, br_eq, br_ne, br_jirl} br_kind_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      res_from_mem;
        logic      gr_we;
        logic      mem_we;
        logic      is_load;
        logic      is_store;
        br_kind_t  br_kind;
        reg_addr_t dest;
    } ctrl_t;

endpackage

//--- cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// first fetch address after reset.
`define RESET_PC 32'h1c00_0000

// data path width.
`define XLEN 32

// architectural register count, r0 included.
`define NUM_REGS 32

`endif
